/* include/alu_defs.svh */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

`define ALU_W       32  // Datapath width
`define CTRL_W      4   // Operation code width

// Single-cycle codes
`define OP_ADD      4'd0
`define OP_SUB      4'd1
`define OP_AND      4'd2
`define OP_OR       4'd3
`define OP_XOR      4'd4
`define OP_SLL      4'd5
`define OP_SRL      4'd6
`define OP_SRA      4'd7
`define OP_MULT_LO  4'd8
`define OP_MULT_HI  4'd9
`define OP_MULTU_LO 4'd10
`define OP_MULTU_HI 4'd11

// Codes served by the divider
`define OP_DIV      4'd12
`define OP_MOD      4'd13
`define OP_DIVU     4'd14
`define OP_MODU     4'd15

`define DIV_CYCLES  `ALU_W  // One quotient bit per cycle

`endif

/* design/alu_pkg.sv */
`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

    // Signed compare of a against b
    typedef enum logic [1:0] {
        CMP_EQ = 2'd0,
        CMP_LT = 2'd1,  // a < b
        CMP_GT = 2'd2   // a > b
    } cmp_t;

    // Request payload, 68 bits
    typedef struct packed {
        logic [`CTRL_W-1:0] ctrl;
        logic [`ALU_W-1:0]  a;
        logic [`ALU_W-1:0]  b;
    } alu_op_t;

    // Response payload, 34 bits
    typedef struct packed {
        logic [`ALU_W-1:0] out;
        cmp_t              comp;
    } alu_res_t;

endpackage

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module alu import alu_pkg::*; (
    input  logic [`CTRL_W-1:0] ctrl,
    input  logic [`ALU_W-1:0]  a,
    input  logic [`ALU_W-1:0]  b,
    output logic [`ALU_W-1:0]  out,
    output cmp_t               comp
);

    localparam int MSB  = `ALU_W - 1;
    localparam int SH_W = $clog2(`ALU_W);  // Shift amount bits

    logic [`ALU_W-1:0]   a_mag;     // |a| when read as signed
    logic [`ALU_W-1:0]   b_mag;
    logic [2*`ALU_W-1:0] prod_u;    // Unsigned product
    logic [2*`ALU_W-1:0] prod_mag;  // Product of magnitudes
    logic [2*`ALU_W-1:0] prod_s;    // Signed product
    logic                prod_neg;
    logic [SH_W-1:0]     shamt;

    assign shamt = b[SH_W-1:0];  // Upper bits of b ignored

    // Both products always computed, ctrl only picks the half
    always_comb begin
        a_mag    = a[MSB] ? (~a + 1'b1) : a;  // Most negative stays 2^31, still right unsigned
        b_mag    = b[MSB] ? (~b + 1'b1) : b;
        prod_u   = {{`ALU_W{1'b0}}, a} * {{`ALU_W{1'b0}}, b};
        prod_mag = {{`ALU_W{1'b0}}, a_mag} * {{`ALU_W{1'b0}}, b_mag};
        prod_neg = a[MSB] ^ b[MSB];  // Signs differ
        prod_s   = prod_neg ? (~prod_mag + 1'b1) : prod_mag;
    end

    // Compare ignores ctrl
    always_comb begin
        if ($signed(a) < $signed(b)) begin
            comp = CMP_LT;
        end else if ($signed(a) > $signed(b)) begin
            comp = CMP_GT;
        end else begin
            comp = CMP_EQ;
        end
    end

    always_comb begin
        case (ctrl)
            `OP_ADD:      out = a + b;  // Wraps
            `OP_SUB:      out = a - b;
            `OP_AND:      out = a & b;
            `OP_OR:       out = a | b;
            `OP_XOR:      out = a ^ b;
            `OP_SLL:      out = a << shamt;
            `OP_SRL:      out = a >> shamt;
            `OP_SRA:      out = $signed(a) >>> shamt;  // Sign fill
            `OP_MULT_LO:  out = prod_s[MSB:0];
            `OP_MULT_HI:  out = prod_s[2*`ALU_W-1:`ALU_W];
            `OP_MULTU_LO: out = prod_u[MSB:0];
            `OP_MULTU_HI: out = prod_u[2*`ALU_W-1:`ALU_W];
            // Divide codes, exec_ctrl takes the divider result instead
            default:      out = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module divider (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,      // One-cycle pulse
    input  logic              sign_mode,  // 1 for DIV/MOD
    input  logic [`ALU_W-1:0] dividend,
    input  logic [`ALU_W-1:0] divisor,
    output logic [`ALU_W-1:0] quotient,
    output logic [`ALU_W-1:0] remainder,
    output logic              done
);

    localparam int MSB   = `ALU_W - 1;
    localparam int CNT_W = $clog2(`DIV_CYCLES + 1);

    logic [CNT_W-1:0] cnt;      // Steps left
    logic             busy;     // Shift-subtract phase
    logic             fin;      // Sign fixup cycle

    logic [`ALU_W-1:0] rem;     // Partial remainder
    logic [`ALU_W-1:0] quo;     // Dividend bits shift out, quotient bits shift in
    logic [`ALU_W-1:0] dsr;     // Divisor magnitude
    logic [`ALU_W-1:0] dvd_raw; // Original dividend for the special cases
    logic              neg_q;
    logic              neg_r;
    logic              div_zero;
    logic              ovf;     // Most negative / -1

    logic [`ALU_W:0]   shift_rem;  // Remainder with next dividend bit
    logic [`ALU_W:0]   diff;
    logic [`ALU_W-1:0] rem_next;
    logic [`ALU_W-1:0] quo_next;
    logic [`ALU_W-1:0] q_fix;
    logic [`ALU_W-1:0] r_fix;

    // One restoring step
    always_comb begin
        shift_rem = {rem, quo[MSB]};
        diff      = shift_rem - {1'b0, dsr};
        if (!diff[`ALU_W]) begin  // No borrow, subtract holds
            rem_next = diff[MSB:0];
            quo_next = {quo[MSB-1:0], 1'b1};
        end else begin            // Restore
            rem_next = shift_rem[MSB:0];
            quo_next = {quo[MSB-1:0], 1'b0};
        end
    end

    // Final signs, then the fixed rules on top
    always_comb begin
        q_fix = neg_q ? (~quo + 1'b1) : quo;
        r_fix = neg_r ? (~rem + 1'b1) : rem;
        if (div_zero) begin
            q_fix = '1;
            r_fix = dvd_raw;
        end else if (ovf) begin
            q_fix = dvd_raw;
            r_fix = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            fin  <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= fin;  // Pulse right after fixup
            fin  <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`DIV_CYCLES);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1)) begin  // Last step
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            rem      <= '0;
            quo      <= (sign_mode && dividend[MSB]) ? (~dividend + 1'b1) : dividend;
            dsr      <= (sign_mode && divisor[MSB]) ? (~divisor + 1'b1) : divisor;
            dvd_raw  <= dividend;
            neg_q    <= sign_mode && (dividend[MSB] ^ divisor[MSB]);
            neg_r    <= sign_mode && dividend[MSB];  // Remainder follows dividend
            div_zero <= (divisor == '0);
            ovf      <= sign_mode && (dividend == {1'b1, {MSB{1'b0}}}) && (divisor == '1);
        end else if (busy) begin
            rem <= rem_next;
            quo <= quo_next;
        end
        if (fin) begin
            quotient  <= q_fix;
            remainder <= r_fix;
        end
    end

endmodule

`default_nettype wire

/* design/exec_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module exec_ctrl import alu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    // Requester side
    input  logic              req,
    input  alu_op_t           op,
    output logic              ack,
    output alu_res_t          res,
    // To alu
    output alu_op_t           cur_op,  // Latched request
    input  logic [`ALU_W-1:0] alu_out,
    input  cmp_t              alu_comp,
    // Divider
    output logic              div_start,
    output logic              div_signed,
    input  logic [`ALU_W-1:0] div_q,
    input  logic [`ALU_W-1:0] div_r,
    input  logic              div_done
);

    typedef enum logic [2:0] {
        IDLE,      // Waiting for req
        EXEC,      // alu result ready, or divider kicked off
        DIV_WAIT,  // Divider running
        HOLD,      // ack high until req drops
        RELEASE    // Lower ack
    } state_t;

    state_t state;
    logic   is_div;    // Code served by divider
    logic   want_rem;  // MOD/MODU take remainder

    // Only place the divide codes are decoded
    always_comb begin
        is_div     = (cur_op.ctrl == `OP_DIV)  || (cur_op.ctrl == `OP_MOD) ||
                     (cur_op.ctrl == `OP_DIVU) || (cur_op.ctrl == `OP_MODU);
        div_signed = (cur_op.ctrl == `OP_DIV)  || (cur_op.ctrl == `OP_MOD);
        want_rem   = (cur_op.ctrl == `OP_MOD)  || (cur_op.ctrl == `OP_MODU);
    end

    assign div_start = (state == EXEC) && is_div;  // Single cycle, EXEC lasts one

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) state <= EXEC;
                end
                EXEC: begin
                    if (is_div) begin
                        state <= DIV_WAIT;
                    end else begin
                        state <= HOLD;
                        ack   <= 1'b1;  // Two edges after req seen
                    end
                end
                DIV_WAIT: begin
                    if (div_done) begin
                        state <= HOLD;
                        ack   <= 1'b1;
                    end
                end
                HOLD: begin
                    // Back-pressure: stay here as long as req is held
                    if (!req) state <= RELEASE;
                end
                RELEASE: begin
                    ack   <= 1'b0;  // req already seen low
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            cur_op <= op;  // op stable while req high
        end
        if (state == EXEC && !is_div) begin
            res.out  <= alu_out;
            res.comp <= alu_comp;
        end
        if (state == DIV_WAIT && div_done) begin
            res.out  <= want_rem ? div_r : div_q;
            res.comp <= alu_comp;  // cur_op unchanged, compare still valid
        end
    end

endmodule

`default_nettype wire

/* design/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module exec_top import alu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,
    input  alu_op_t  op,
    output logic     ack,
    output alu_res_t res
);

    alu_op_t           cur_op;      // Operation held by the controller
    logic [`ALU_W-1:0] alu_out;
    cmp_t              alu_comp;
    logic              div_start;
    logic              div_signed;
    logic [`ALU_W-1:0] div_q;
    logic [`ALU_W-1:0] div_r;
    logic              div_done;

    exec_ctrl exec_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .ack        (ack),
        .res        (res),
        .cur_op     (cur_op),
        .alu_out    (alu_out),
        .alu_comp   (alu_comp),
        .div_start  (div_start),
        .div_signed (div_signed),
        .div_q      (div_q),
        .div_r      (div_r),
        .div_done   (div_done)
    );

    alu alu_inst (
        .ctrl (cur_op.ctrl),
        .a    (cur_op.a),
        .b    (cur_op.b),
        .out  (alu_out),
        .comp (alu_comp)
    );

    // Operands straight from the latched request
    divider divider_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .sign_mode (div_signed),
        .dividend  (cur_op.a),
        .divisor   (cur_op.b),
        .quotient  (div_q),
        .remainder (div_r),
        .done      (div_done)
    );

endmodule

`default_nettype wire

/* bench/exec_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module exec_asserts import alu_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     req,
    input logic     ack,
    input alu_res_t res
);

    // ack only answers a pending req
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req)
    ) else $error("ack rose without a pending req");

    // Response frozen for the whole ack phase
    res_stable: assert property (
        @(posedge clk) disable iff (!rst_n) (ack && $past(ack)) |-> $stable(res)
    ) else $error("res changed while ack was high");

    ack_held: assert property (
        @(posedge clk) disable iff (!rst_n) (ack && req) |=> ack
    ) else $error("ack dropped while req was still high");

    // Controller comes out of reset idle
    ack_low_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !ack
    ) else $error("ack was high right after reset release");

endmodule

bind exec_ctrl exec_asserts exec_asserts_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .ack   (ack),
    .res   (res)
);

`default_nettype wire

/* bench/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_defs.svh"

module exec_tb import alu_pkg::*; ();

    localparam string TRACE_FILE = "bench/exec_trace.txt";
    localparam int    ACK_LIMIT  = `DIV_CYCLES + 8;  // Edges allowed per handshake phase

    logic     clk;
    logic     rst_n;
    logic     req;
    alu_op_t  op;
    logic     ack;
    alu_res_t res;

    alu_op_t           ops[$];        // Trace requests
    logic [`ALU_W-1:0] exp_outs[$];
    cmp_t              exp_comps[$];
    logic              trace_loaded;  // Starts the watchdog

    exec_top exec_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .op    (op),
        .ack   (ack),
        .res   (res)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_out(input logic [`ALU_W-1:0] got, input logic [`ALU_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: res.out got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic check_comp(input cmp_t got, input cmp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: res.comp got %0d (%s) expected %0d (%s)",
                                $time, got, got.name(), exp, exp.name()));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("error at %0t: ack latency got %0d expected %0d edges",
                                $time, got, exp));
        end
    endtask

    // One op per line
    // Lines starting with # are comments
    task automatic load_trace();
        int                 fd;
        int                 cnt;
        string              line;
        logic [`CTRL_W-1:0] ctrl;
        logic [`ALU_W-1:0]  a;
        logic [`ALU_W-1:0]  b;
        logic [`ALU_W-1:0]  out;
        logic [1:0]         comp;
        alu_op_t            item;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) abort_run({"could not open the trace file ", TRACE_FILE});
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") continue;
            cnt = $sscanf(line, "%h %h %h %h %h", ctrl, a, b, out, comp);
            if (cnt == 5) begin
                item = '{ctrl: ctrl, a: a, b: b};
                ops.push_back(item);
                exp_outs.push_back(out);
                exp_comps.push_back(cmp_t'(comp));
            end else if (cnt > 0) begin
                abort_run({"malformed trace line: ", line});
            end
        end
        $fclose(fd);
        if (ops.size() == 0) abort_run("the trace file holds no operations");
    endtask

    // Entered and left on a rising edge
    task automatic run_op(input alu_op_t cur, input logic [`ALU_W-1:0] exp_out,
                          input cmp_t exp_comp);
        int   edges;
        int   extra;
        int   gap;
        logic is_div;
        is_div = (cur.ctrl >= `OP_DIV);  // Divider codes at the top
        edges  = 0;
        op  <= cur;
        req <= 1'b1;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);  // Sample away from the driving edge
            if (edges > ACK_LIMIT) abort_run("ack never rose for a pending req");
        end while (!ack);
        if (!is_div) check_latency(edges, 2);
        check_out(res.out, exp_out);
        check_comp(res.comp, exp_comp);
        extra = $urandom_range(0, 3);  // Back-pressure
        repeat (extra) begin
            @(posedge clk);
            @(negedge clk);
            check_out(res.out, exp_out);
            check_comp(res.comp, exp_comp);
        end
        @(posedge clk);
        req  <= 1'b0;
        op.a <= $urandom();  // Junk operands while idle
        op.b <= $urandom();
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (edges > ACK_LIMIT) abort_run("ack did not fall after req was lowered");
        end while (ack);
        gap = $urandom_range(0, 3);
        repeat (gap) @(posedge clk);
        @(posedge clk);
    endtask

    initial begin
        req          = 1'b0;
        op           = '0;
        rst_n        = 1'b0;
        trace_loaded = 1'b0;
        void'($urandom(32'hf4c718c0));  // Seed once
        load_trace();
        trace_loaded = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        foreach (ops[i]) begin
            run_op(ops[i], exp_outs[i], exp_comps[i]);
        end
        $display("TEST OK");
        $finish;
    end

    // Watchdog budget scales with trace length
    initial begin
        int limit;
        wait (trace_loaded);
        limit = ops.size() * (`DIV_CYCLES + 12) + 20;  // Reset cycles on top
        repeat (limit) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles, the DUT stopped responding",
                            limit));
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
design/alu_pkg.sv
design/alu.sv
design/divider.sv
design/exec_ctrl.sv
design/exec_top.sv
bench/exec_asserts.sv
bench/exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the exec_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f list.f --top-module exec_tb -o Vexec_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vexec_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

# Verdict from the log, exit status as a backstop
if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation passed"
exit 0

/* bench/exec_trace.txt */
# ctrl a b expected_out expected_comp, all hex
# comp 0 equal, 1 a below b, 2 a above b (signed)
0 00000005 00000003 00000008 2
0 ffffffff 00000001 00000000 1
0 7fffffff 00000001 80000000 2
1 00000000 00000001 ffffffff 1
1 12345678 12345678 00000000 0
2 f0f0f0f0 ff00ff00 f000f000 1
3 f0f0f0f0 0f0f0f0f ffffffff 1
4 aaaaaaaa 55555555 ffffffff 1
5 00000001 00000024 00000010 1
6 80000000 0000001f 00000001 1
7 80000000 00000004 f8000000 1
7 f0000000 00000104 ff000000 1
8 fffffffd 00000007 ffffffeb 1
9 fffffffd 00000007 ffffffff 1
9 80000000 80000000 40000000 0
8 80000000 ffffffff 80000000 1
a ffffffff ffffffff 00000001 0
b ffffffff ffffffff fffffffe 0
c fffffff9 00000002 fffffffd 1
d fffffff9 00000002 ffffffff 1
c 00000007 fffffffe fffffffd 2
d 00000007 fffffffe 00000001 2
e fffffff9 00000002 7ffffffc 1
f fffffff9 00000002 00000001 1
c 00000064 00000000 ffffffff 2
d 00000064 00000000 00000064 2
c 80000000 ffffffff 80000000 1
d 80000000 ffffffff 00000000 1
e 80000000 00000000 ffffffff 1
0 80000001 00000001 80000002 1
1 00000001 80000001 80000000 2
